// File: Bender.yml
package:
  name: axis_fifo

sources:
  # Packages first, then the RAM, FIFO, counter and top level
  - files:
      - design/axis_pkg.sv
      - design/fifo_pkg.sv
      - design/dist_ram.sv
      - design/axis_dist_ram_fifo.sv
      - design/axis_pkt_counter.sv
      - design/axis_fifo_top.sv

  # Checker and testbench for simulation
  - target: test
    files:
      - tb/axis_fifo_checker.sv
      - tb/axis_fifo_tb.sv

// File: design/axis_dist_ram_fifo.sv
// AXI-Stream FIFO in distributed RAM

`timescale 1ns/100ps

module axis_dist_ram_fifo
    import axis_pkg::*, fifo_pkg::*;
(
    input  logic               clk_ifc,
    input  logic               reset,

    // Upstream side
    input  logic [DATA_W-1:0]  in_tdata,
    input  logic [KEEP_W-1:0]  in_tkeep,
    input  logic               in_tlast,
    input  logic               in_tvalid,
    output logic               in_tready,

    // Downstream side
    output logic [DATA_W-1:0]  out_tdata,
    output logic [KEEP_W-1:0]  out_tkeep,
    output logic               out_tlast,
    output logic               out_tvalid,
    input  logic               out_tready,

    // Status
    output logic [COUNT_W-1:0] fill_count,
    output logic               axis_in_overflow,
    output logic               axis_out_underflow
);

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and occupancy

    logic [ADDR_W-1:0]  wr_ptr;
    logic [ADDR_W-1:0]  rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               full;
    logic               empty;
    logic               wr_en;
    logic               rd_en;

    // Beat in and out of the RAM
    axis_beat_t         wr_beat;
    axis_beat_t         rd_beat;

    // Flags come straight off the registered count
    assign full  = (count == COUNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);

    // Ready does not look at in_tvalid
    assign in_tready  = ~full;
    assign out_tvalid = ~empty;

    // Transfer strobes
    assign wr_en = in_tvalid & ~full;
    assign rd_en = out_tready & ~empty;

    assign fill_count = count;

    // Pointers wrap naturally at FIFO_DEPTH
    always_ff @(posedge clk_ifc) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, unchanged on simultaneous read and write
    always_ff @(posedge clk_ifc) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Storage

    // Pack input beat
    assign wr_beat.tdata = in_tdata;
    assign wr_beat.tkeep = in_tkeep;
    assign wr_beat.tlast = in_tlast;

    dist_ram u_ram (
        .clk_ifc (clk_ifc),
        .wr_en   (wr_en),
        .wr_addr (wr_ptr),
        .wr_beat (wr_beat),
        .rd_addr (rd_ptr),
        .rd_beat (rd_beat)
    );

    // Head of FIFO drives the output directly
    assign out_tdata = rd_beat.tdata;
    assign out_tkeep = rd_beat.tkeep;
    assign out_tlast = rd_beat.tlast;

    ////////////////////////////////////////////////////////////////////////////
    // Status pulses

    // Stalled write, or read against an empty FIFO
    // One cycle high after the offending edge
    always_ff @(posedge clk_ifc) begin
        if (reset) begin
            axis_in_overflow   <= 1'b0;
            axis_out_underflow <= 1'b0;
        end else begin
            axis_in_overflow   <= in_tvalid & full;
            axis_out_underflow <= out_tready & empty;
        end
    end

endmodule

// File: design/axis_fifo_top.sv
// Stream FIFO with output statistics

`timescale 1ns/100ps

module axis_fifo_top
    import axis_pkg::*, fifo_pkg::*;
(
    input  logic                    clk_ifc,
    input  logic                    reset,

    // Input stream
    input  logic [DATA_W-1:0]       in_tdata,
    input  logic [KEEP_W-1:0]       in_tkeep,
    input  logic                    in_tlast,
    input  logic                    in_tvalid,
    output logic                    in_tready,

    // Output stream
    output logic [DATA_W-1:0]       out_tdata,
    output logic [KEEP_W-1:0]       out_tkeep,
    output logic                    out_tlast,
    output logic                    out_tvalid,
    input  logic                    out_tready,

    // Status and statistics
    output logic                    axis_in_overflow,
    output logic                    axis_out_underflow,
    output logic [COUNT_W-1:0]      fill_count,
    output logic [PKT_COUNT_W-1:0]  pkt_count,
    output logic [BYTE_COUNT_W-1:0] byte_count
);

    ////////////////////////////////////////////////////////////////////////////
    // FIFO

    axis_dist_ram_fifo u_fifo (
        .clk_ifc            (clk_ifc),
        .reset              (reset),
        .in_tdata           (in_tdata),
        .in_tkeep           (in_tkeep),
        .in_tlast           (in_tlast),
        .in_tvalid          (in_tvalid),
        .in_tready          (in_tready),
        .out_tdata          (out_tdata),
        .out_tkeep          (out_tkeep),
        .out_tlast          (out_tlast),
        .out_tvalid         (out_tvalid),
        .out_tready         (out_tready),
        .fill_count         (fill_count),
        .axis_in_overflow   (axis_in_overflow),
        .axis_out_underflow (axis_out_underflow)
    );

    // Counter snoops the output handshake
    axis_pkt_counter u_counter (
        .clk_ifc    (clk_ifc),
        .reset      (reset),
        .tkeep      (out_tkeep),
        .tlast      (out_tlast),
        .tvalid     (out_tvalid),
        .tready     (out_tready),
        .pkt_count  (pkt_count),
        .byte_count (byte_count)
    );

endmodule

// File: design/axis_pkg.sv
// AXI-Stream beat definitions

package axis_pkg;

    // Bytes carried by one beat
    localparam int DATA_BYTES = 8;

    // tdata width in bits
    localparam int DATA_W = DATA_BYTES * 8;

    // One tkeep bit per data byte
    localparam int KEEP_W = DATA_BYTES;

    // Beat as stored in the FIFO RAM
    // 64 data + 8 keep + 1 last = 73 bits
    typedef struct packed {
        logic [DATA_W-1:0] tdata;
        logic [KEEP_W-1:0] tkeep;
        logic              tlast;
    } axis_beat_t;

    // tstrb, tid, tdest and tuser are not carried

endpackage

// File: design/axis_pkt_counter.sv
// Output packet and byte statistics

`timescale 1ns/100ps

module axis_pkt_counter
    import axis_pkg::*, fifo_pkg::*;
(
    input  logic                    clk_ifc,
    input  logic                    reset,
    input  logic [KEEP_W-1:0]       tkeep,
    input  logic                    tlast,
    input  logic                    tvalid,
    input  logic                    tready,
    output logic [PKT_COUNT_W-1:0]  pkt_count,
    output logic [BYTE_COUNT_W-1:0] byte_count
);

    logic                    xfer;
    logic [BYTE_COUNT_W-1:0] beat_bytes;

    // Beat moves on this edge
    assign xfer = tvalid & tready;

    // Population count of tkeep
    always_comb begin
        beat_bytes = '0;
        for (int i = 0; i < KEEP_W; i++) begin
            beat_bytes = beat_bytes + BYTE_COUNT_W'(tkeep[i]);
        end
    end

    // Both counters wrap
    always_ff @(posedge clk_ifc) begin
        if (reset) begin
            pkt_count  <= '0;
            byte_count <= '0;
        end else if (xfer) begin
            // Packet done on its last beat
            if (tlast) begin
                pkt_count <= pkt_count + 1'b1;
            end
            byte_count <= byte_count + beat_bytes;
        end
    end

endmodule

// File: design/dist_ram.sv
// Distributed RAM for stream beats

`timescale 1ns/100ps

module dist_ram
    import axis_pkg::*, fifo_pkg::*;
(
    input  logic              clk_ifc,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  axis_beat_t        wr_beat,
    input  logic [ADDR_W-1:0] rd_addr,
    output axis_beat_t        rd_beat
);

    // Storage array, maps onto LUT RAM
    axis_beat_t mem [0:FIFO_DEPTH-1];

    // Write port
    // Contents are don't-care until written
    always_ff @(posedge clk_ifc) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    // Read port, no output register
    // Data written at an edge is visible right after it
    assign rd_beat = mem[rd_addr];

endmodule

// File: design/fifo_pkg.sv
// FIFO sizing and statistics widths

package fifo_pkg;

    // Stored beats
    localparam int FIFO_DEPTH = 32;

    // RAM address, pointers wrap at FIFO_DEPTH
    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    // Occupancy has to reach FIFO_DEPTH itself
    localparam int COUNT_W = $clog2(FIFO_DEPTH + 1);

    // Output statistics, both wrap
    localparam int PKT_COUNT_W  = 16;
    localparam int BYTE_COUNT_W = 24;

endpackage

// File: project.f
design/axis_pkg.sv
design/fifo_pkg.sv
design/dist_ram.sv
design/axis_dist_ram_fifo.sv
design/axis_pkt_counter.sv
design/axis_fifo_top.sv
tb/axis_fifo_checker.sv
tb/axis_fifo_tb.sv

// File: tb/axis_fifo_checker.sv
// FIFO protocol assertions

`timescale 1ns/100ps

module axis_fifo_checker
    import axis_pkg::*, fifo_pkg::*;
(
    input logic               clk_ifc,
    input logic               reset,
    input logic               in_tvalid,
    input logic               in_tready,
    input logic [DATA_W-1:0]  out_tdata,
    input logic [KEEP_W-1:0]  out_tkeep,
    input logic               out_tlast,
    input logic               out_tvalid,
    input logic               out_tready,
    input logic [COUNT_W-1:0] count,
    input logic               axis_in_overflow,
    input logic               axis_out_underflow
);

    // Failed assertions, polled by the testbench
    int unsigned assert_fails = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Flags and occupancy

    // Ready only while there is room left
    a_ready_not_full: assert property (@(posedge clk_ifc) disable iff (reset)
        in_tready == (count < COUNT_W'(FIFO_DEPTH)))
        else begin
            $error("in_tready does not follow the occupancy");
            assert_fails++;
        end

    a_count_range: assert property (@(posedge clk_ifc) disable iff (reset)
        count <= COUNT_W'(FIFO_DEPTH))
        else begin
            $error("occupancy above FIFO depth");
            assert_fails++;
        end

    ////////////////////////////////////////////////////////////////////////////
    // Output held while stalled

    a_out_stable: assert property (@(posedge clk_ifc) disable iff (reset)
        (out_tvalid && !out_tready) |=>
            (out_tvalid && $stable({out_tdata, out_tkeep, out_tlast})))
        else begin
            $error("output beat changed while out_tready low");
            assert_fails++;
        end

    // Status pulses lag the port-level stall by one edge
    a_overflow: assert property (@(posedge clk_ifc) disable iff (reset)
        1'b1 |=> (axis_in_overflow == $past(in_tvalid && !in_tready)))
        else begin
            $error("axis_in_overflow does not match stalled write");
            assert_fails++;
        end

    a_underflow: assert property (@(posedge clk_ifc) disable iff (reset)
        1'b1 |=> (axis_out_underflow == $past(out_tready && !out_tvalid)))
        else begin
            $error("axis_out_underflow does not match empty read");
            assert_fails++;
        end

endmodule

bind axis_dist_ram_fifo axis_fifo_checker u_checker (.*);

// File: tb/axis_fifo_tb.sv
// Stream FIFO testbench

`timescale 1ns/100ps

module axis_fifo_tb;
    import axis_pkg::*;
    import fifo_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'h7f91;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam int BEAT_TIMEOUT  = 200;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int MIN_PKT_LEN   = 1;
    localparam int MAX_PKT_LEN   = 40;

    logic                    clk_ifc;
    logic                    reset;
    logic [DATA_W-1:0]       in_tdata;
    logic [KEEP_W-1:0]       in_tkeep;
    logic                    in_tlast;
    logic                    in_tvalid;
    logic                    in_tready;
    logic [DATA_W-1:0]       out_tdata;
    logic [KEEP_W-1:0]       out_tkeep;
    logic                    out_tlast;
    logic                    out_tvalid;
    logic                    out_tready;
    logic                    axis_in_overflow;
    logic                    axis_out_underflow;
    logic [COUNT_W-1:0]      fill_count;
    logic [PKT_COUNT_W-1:0]  pkt_count;
    logic [BYTE_COUNT_W-1:0] byte_count;

    // Scoreboard and expected statistics
    axis_beat_t  sb_q [$];
    int          exp_pkts = 0;
    int          exp_bytes = 0;
    logic        in_taken = 1'b0;
    logic        random_ready = 1'b0;
    logic [31:0] lfsr_state = LFSR_SEED;

    axis_fifo_top UUT (.*);

    initial begin
        clk_ifc = 1'b0;
        forever #4 clk_ifc = ~clk_ifc;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Sample handshakes, advance to 1 ns after the next edge
    task automatic clock_cycle();
        axis_beat_t head;
        in_taken = in_tvalid && in_tready;
        if (in_taken) begin
            sb_q.push_back({in_tdata, in_tkeep, in_tlast});
        end
        if (out_tvalid && out_tready) begin
            if (sb_q.size() == 0) begin
                abort_run("Output beat appeared with nothing written to the FIFO");
            end
            head = sb_q.pop_front();
            check_value("out_tdata", out_tdata, head.tdata);
            check_value("out_tkeep", out_tkeep, head.tkeep);
            check_value("out_tlast", out_tlast, head.tlast);
            exp_bytes += $countones(head.tkeep);
            if (head.tlast) begin
                exp_pkts++;
            end
        end
        @(posedge clk_ifc);
        #1;
        if (UUT.u_fifo.u_checker.assert_fails != 0) begin
            abort_run("A protocol assertion failed");
        end
        if (random_ready) begin
            out_tready = (rand_bits(1) != '0);
        end
    endtask

    // Valid stays high on return, caller drops it
    task automatic send_beat(input logic [DATA_W-1:0] data, input logic [KEEP_W-1:0] keep,
                             input logic last);
        int waited;
        waited = 0;
        in_tdata  = data;
        in_tkeep  = keep;
        in_tlast  = last;
        in_tvalid = 1'b1;
        clock_cycle();
        while (!in_taken) begin
            waited++;
            if (waited > BEAT_TIMEOUT) begin
                abort_run("Timed out waiting for the FIFO to accept a beat");
            end
            clock_cycle();
        end
    endtask

    // Runs until every accepted beat has left
    task automatic wait_drained();
        int waited;
        waited = 0;
        while (sb_q.size() != 0) begin
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                abort_run("Timed out waiting for the FIFO to drain");
            end
            clock_cycle();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic test_reset_state();
        check_value("in_tready", in_tready, 1);
        check_value("out_tvalid", out_tvalid, 0);
        check_value("axis_in_overflow", axis_in_overflow, 0);
        check_value("axis_out_underflow", axis_out_underflow, 0);
        check_value("fill_count", fill_count, 0);
        check_value("pkt_count", pkt_count, 0);
        check_value("byte_count", byte_count, 0);
    endtask

    task automatic test_single_packet();
        logic [KEEP_W-1:0] keeps [3];
        keeps = '{8'hff, 8'hff, 8'h0f};
        out_tready = 1'b1;
        for (int i = 0; i < 3; i++) begin
            send_beat(64'h0123_4567_89ab_cd00 | i, keeps[i], i == 2);
            // Beat at the head one cycle after acceptance
            check_value("out_tvalid", out_tvalid, 1);
            check_value("out_tdata", out_tdata, 64'h0123_4567_89ab_cd00 | i);
        end
        in_tvalid = 1'b0;
        wait_drained();
        check_value("pkt_count", pkt_count, 1);
        check_value("byte_count", byte_count, 20);
    endtask

    task automatic test_fill_stall();
        out_tready = 1'b0;
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            send_beat(64'hf111_0000_0000_0000 | i, 8'hff, i == FIFO_DEPTH - 1);
        end
        // Beat 33 offered against a full FIFO, held stable until taken
        in_tdata = 64'hf111_0000_0000_0021;
        in_tkeep = 8'h3f;
        in_tlast = 1'b1;
        check_value("in_tready", in_tready, 0);
        check_value("fill_count", fill_count, FIFO_DEPTH);
        check_value("axis_in_overflow", axis_in_overflow, 0);
        for (int i = 0; i < 4; i++) begin
            clock_cycle();
            check_value("axis_in_overflow", axis_in_overflow, 1);
            check_value("in_tready", in_tready, 0);
        end
        out_tready = 1'b1;
        send_beat(64'hf111_0000_0000_0021, 8'h3f, 1'b1);
        in_tvalid = 1'b0;
        wait_drained();
    endtask

    task automatic test_empty_read();
        out_tready = 1'b0;
        clock_cycle();
        check_value("axis_out_underflow", axis_out_underflow, 0);
        out_tready = 1'b1;
        for (int i = 0; i < 5; i++) begin
            clock_cycle();
            check_value("axis_out_underflow", axis_out_underflow, 1);
            check_value("out_tvalid", out_tvalid, 0);
        end
    endtask

    task automatic test_random_traffic();
        int                pkts_before;
        int                len;
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        pkts_before  = exp_pkts;
        random_ready = 1'b1;
        for (int p = 0; p < 20; p++) begin
            len = MIN_PKT_LEN + rand_bits(6) % (MAX_PKT_LEN - MIN_PKT_LEN + 1);
            for (int b = 0; b < len; b++) begin
                data = '0;
                for (int k = 0; k < DATA_BYTES; k++) begin
                    data = (data << 8) | DATA_W'(rand_bits(8));
                end
                // Final beat keeps 1 to 8 low bytes
                keep = (b == len - 1) ? KEEP_W'((1 << (rand_bits(3) + 1)) - 1) : 8'hff;
                send_beat(data, keep, b == len - 1);
            end
        end
        in_tvalid    = 1'b0;
        random_ready = 1'b0;
        out_tready   = 1'b1;
        wait_drained();
        check_value("pkt_count", pkt_count, pkts_before + 20);
        check_value("byte_count", byte_count, BYTE_COUNT_W'(exp_bytes));
        check_value("fill_count", fill_count, 0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence

    initial begin
        reset      = 1'b1;
        in_tdata   = '0;
        in_tkeep   = '0;
        in_tlast   = 1'b0;
        in_tvalid  = 1'b0;
        out_tready = 1'b0;
        repeat (8) @(posedge clk_ifc);
        #1;
        reset = 1'b0;
        test_reset_state();
        test_single_packet();
        test_fill_stall();
        test_empty_read();
        test_random_traffic();
        if (UUT.u_fifo.u_checker.assert_fails == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abort_run("Protocol assertions failed during the run");
        end
    end

endmodule
